// ==== hdl/dma_pkg.sv ====
package dma_pkg;

    // Burst IDs wrap modulo 2**ID_WIDTH
    localparam int ID_WIDTH = 3;

    localparam int DATA_WIDTH = 32;

    // Beat counter inside one burst
    localparam int BEAT_CNT_WIDTH = 4;

    // Beats in a full burst, must match the counter range
    localparam int BURST_BEATS = 16;

    // Transfer length field holds beats minus one
    localparam int XFER_LEN_WIDTH = 8;

    // Bursts in flight, kept below 2**ID_WIDTH so the ID distance stays unambiguous
    localparam int MAX_OUTSTANDING = 4;

endpackage

// ==== hdl/burst_splitter.sv ====
`timescale 1ns/1ps

module burst_splitter (
    input  logic                                 clk,
    input  logic                                 resetn,

    input  logic                                 enable,
    input  logic                                 enabled,

    input  logic                                 xfer_valid,
    input  logic [dma_pkg::XFER_LEN_WIDTH-1:0]   xfer_beats,
    output logic                                 xfer_ready,

    input  logic [dma_pkg::ID_WIDTH-1:0]         response_id,
    input  logic                                 req_ready,
    output logic [dma_pkg::ID_WIDTH-1:0]         request_id,
    output logic                                 req_valid,
    output logic [dma_pkg::BEAT_CNT_WIDTH-1:0]   req_last_burst_length,
    output logic                                 eot
);

    // Up to 2**(XFER_LEN_WIDTH-BEAT_CNT_WIDTH) bursts, one extra bit for the full count
    logic [dma_pkg::XFER_LEN_WIDTH-dma_pkg::BEAT_CNT_WIDTH:0] bursts_left;
    logic [dma_pkg::XFER_LEN_WIDTH-dma_pkg::BEAT_CNT_WIDTH:0] bursts_left_nxt;
    logic [dma_pkg::XFER_LEN_WIDTH-dma_pkg::BEAT_CNT_WIDTH:0] bursts_total;

    logic [dma_pkg::ID_WIDTH-1:0] request_id_nxt;
    logic [dma_pkg::ID_WIDTH-1:0] id_gap;
    logic [dma_pkg::ID_WIDTH-1:0] id_gap_nxt;

    logic xfer_fire;
    logic issue;
    logic eot_nxt;

    // Full bursts plus the final one, which may also be full
    assign bursts_total = {1'b0, xfer_beats[dma_pkg::XFER_LEN_WIDTH-1:dma_pkg::BEAT_CNT_WIDTH]}
                          + 1'b1;

    assign id_gap = request_id - response_id;

    // Idle, data side free, and the previous request already taken
    assign xfer_ready = (bursts_left == '0) && enabled && !req_valid && req_ready;
    assign xfer_fire  = xfer_valid && xfer_ready;

    assign issue = (bursts_left != '0) && enable &&
                   (int'(id_gap) < dma_pkg::MAX_OUTSTANDING);

    always_comb begin
        bursts_left_nxt = bursts_left;
        request_id_nxt  = request_id;
        if (xfer_fire) begin
            bursts_left_nxt = bursts_total;
        end else if (issue) begin
            bursts_left_nxt = bursts_left - 1'b1;
            request_id_nxt  = request_id + 1'b1;
        end
    end

    // Final burst is the one in progress
    assign id_gap_nxt = request_id_nxt - response_id;
    assign eot_nxt    = (bursts_left_nxt == '0) && (int'(id_gap_nxt) == 1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bursts_left <= '0;
            request_id  <= '0;
            eot         <= 1'b0;
        end else begin
            bursts_left <= bursts_left_nxt;
            request_id  <= request_id_nxt;
            eot         <= eot_nxt;
        end
    end

    // Request toward the data side, held until taken
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_valid <= 1'b0;
        end else if (xfer_fire) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_fire) begin
            req_last_burst_length <= xfer_beats[dma_pkg::BEAT_CNT_WIDTH-1:0];
        end
    end

endmodule

// ==== hdl/data_transfer.sv ====
`timescale 1ns/1ps

module data_transfer #(
    parameter int DISABLE_WAIT_FOR_ID = 1
) (
    input  logic                                 clk,
    input  logic                                 resetn,

    input  logic [dma_pkg::ID_WIDTH-1:0]         request_id,
    output logic [dma_pkg::ID_WIDTH-1:0]         response_id,
    input  logic                                 sync_id,
    input  logic                                 eot,

    input  logic                                 enable,
    output logic                                 enabled,

    output logic                                 s_ready,
    input  logic                                 s_valid,
    input  logic [dma_pkg::DATA_WIDTH-1:0]       s_data,

    input  logic                                 m_ready,
    output logic                                 m_valid,
    output logic [dma_pkg::DATA_WIDTH-1:0]       m_data,
    output logic                                 m_last,

    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic [dma_pkg::BEAT_CNT_WIDTH-1:0]   req_last_burst_length
);

    logic [dma_pkg::BEAT_CNT_WIDTH-1:0] last_burst_length;
    logic [dma_pkg::BEAT_CNT_WIDTH-1:0] beat_counter;
    logic [dma_pkg::ID_WIDTH-1:0]       id_nxt;

    logic pending_burst;
    logic beat_fire;
    logic last;
    logic req_fire;

    assign req_fire  = req_valid && req_ready && enabled;
    assign beat_fire = s_valid && s_ready;

    // Full bursts end on beat 15, the final one on its stored length
    assign last = eot ? (beat_counter == last_burst_length)
                      : (int'(beat_counter) == dma_pkg::BURST_BEATS - 1);

    assign s_ready = m_ready && pending_burst && !req_ready;
    assign m_valid = s_valid && pending_burst && !req_ready;
    assign m_data  = s_data;
    assign m_last  = last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            enabled <= 1'b0;
        end else if (enable) begin
            enabled <= 1'b1;
        end else if (DISABLE_WAIT_FOR_ID == 0) begin
            // Let a beat already offered to the sink go first
            if (!m_valid || m_ready) begin
                enabled <= 1'b0;
            end
        end else if (response_id == request_id) begin
            // All issued bursts must drain
            enabled <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_ready    <= 1'b1;
            beat_counter <= '0;
        end else if (!enabled) begin
            req_ready <= 1'b1;
        end else if (req_ready) begin
            if (req_valid) begin
                req_ready    <= 1'b0;
                beat_counter <= '0;
            end
        end else if (beat_fire) begin
            if (last && eot) begin
                req_ready <= 1'b1;
            end
            beat_counter <= beat_counter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            last_burst_length <= req_last_burst_length;
        end
    end

    always_comb begin
        id_nxt = response_id;
        if ((beat_fire && last) || (sync_id && response_id != request_id)) begin
            id_nxt = response_id + 1'b1;
        end
    end

    // One idle cycle after each ID step so eot catches up with the new ID
    always_ff @(posedge clk) begin
        if (!resetn) begin
            response_id   <= '0;
            pending_burst <= 1'b0;
        end else begin
            response_id   <= id_nxt;
            pending_burst <= (id_nxt != request_id) && (id_nxt == response_id);
        end
    end

endmodule

// ==== hdl/transfer_tracker.sv ====
`timescale 1ns/1ps

module transfer_tracker (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [dma_pkg::ID_WIDTH-1:0]  request_id,
    input  logic [dma_pkg::ID_WIDTH-1:0]  response_id,
    input  logic                          req_ready,

    output logic                          busy,
    output logic                          xfer_done,
    output logic [dma_pkg::ID_WIDTH-1:0]  outstanding
);

    logic busy_q;
    logic [dma_pkg::ID_WIDTH-1:0] id_gap;

    // Data side holds req_ready low for the whole transfer
    assign busy = !req_ready;

    // Rising req_ready after a busy cycle
    assign xfer_done = req_ready && busy_q;

    assign id_gap = request_id - response_id;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy;
        end
    end

    // Bursts issued and not yet completed, modulo the ID range
    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= '0;
        end else begin
            outstanding <= id_gap;
        end
    end

endmodule

// ==== hdl/dma_burst_mover.sv ====
`timescale 1ns/1ps

module dma_burst_mover (
    input  logic                                 clk,
    input  logic                                 resetn,

    input  logic                                 enable,
    output logic                                 enabled,
    input  logic                                 sync_id,

    input  logic                                 xfer_valid,
    input  logic [dma_pkg::XFER_LEN_WIDTH-1:0]   xfer_beats,
    output logic                                 xfer_ready,

    input  logic                                 s_valid,
    output logic                                 s_ready,
    input  logic [dma_pkg::DATA_WIDTH-1:0]       s_data,

    output logic                                 m_valid,
    input  logic                                 m_ready,
    output logic [dma_pkg::DATA_WIDTH-1:0]       m_data,
    output logic                                 m_last,

    output logic                                 busy,
    output logic                                 xfer_done,
    output logic [dma_pkg::ID_WIDTH-1:0]         outstanding
);

    logic [dma_pkg::ID_WIDTH-1:0]       request_id;
    logic [dma_pkg::ID_WIDTH-1:0]       response_id;
    logic [dma_pkg::BEAT_CNT_WIDTH-1:0] req_last_burst_length;
    logic                               req_valid;
    logic                               req_ready;
    logic                               eot;

    burst_splitter i_splitter (
        .clk                   (clk),
        .resetn                (resetn),
        .enable                (enable),
        .enabled               (enabled),
        .xfer_valid            (xfer_valid),
        .xfer_beats            (xfer_beats),
        .xfer_ready            (xfer_ready),
        .response_id           (response_id),
        .req_ready             (req_ready),
        .request_id            (request_id),
        .req_valid             (req_valid),
        .req_last_burst_length (req_last_burst_length),
        .eot                   (eot)
    );

    // Drain all bursts before reporting disabled
    data_transfer #(
        .DISABLE_WAIT_FOR_ID (1)
    ) i_data_transfer (
        .clk                   (clk),
        .resetn                (resetn),
        .request_id            (request_id),
        .response_id           (response_id),
        .sync_id               (sync_id),
        .eot                   (eot),
        .enable                (enable),
        .enabled               (enabled),
        .s_ready               (s_ready),
        .s_valid               (s_valid),
        .s_data                (s_data),
        .m_ready               (m_ready),
        .m_valid               (m_valid),
        .m_data                (m_data),
        .m_last                (m_last),
        .req_valid             (req_valid),
        .req_ready             (req_ready),
        .req_last_burst_length (req_last_burst_length)
    );

    transfer_tracker i_tracker (
        .clk         (clk),
        .resetn      (resetn),
        .request_id  (request_id),
        .response_id (response_id),
        .req_ready   (req_ready),
        .busy        (busy),
        .xfer_done   (xfer_done),
        .outstanding (outstanding)
    );

endmodule

// ==== verif/dma_checker.sv ====
`timescale 1ns/1ps

module dma_checker (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 enabled,
    input  logic                                 xfer_valid,
    input  logic [dma_pkg::XFER_LEN_WIDTH-1:0]   xfer_beats,
    input  logic                                 xfer_ready,
    input  logic                                 s_valid,
    input  logic                                 s_ready,
    input  logic                                 m_valid,
    input  logic                                 m_ready,
    input  logic [dma_pkg::DATA_WIDTH-1:0]       m_data,
    input  logic                                 m_last,
    input  logic                                 busy,
    input  logic                                 xfer_done,
    input  logic [dma_pkg::ID_WIDTH-1:0]         outstanding
);

    int error_count;
    int check_count;
    int xfer_count;

    logic [dma_pkg::DATA_WIDTH-1:0] next_data;
    int beats_expected;
    int beat_index;
    int errors_at_start;
    bit active;
    bit done_q;
    bit enabled_q;

    initial begin
        error_count = 0;
        check_count = 0;
        xfer_count  = 0;
        next_data   = '0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // Burst rule: every 16th beat, and the final beat of the transfer
    function automatic bit expected_last(input int index, input int total);
        return ((index % dma_pkg::BURST_BEATS) == 0) || (index == total);
    endfunction

    // Sampled mid-cycle, where inputs and registered outputs are settled
    always @(negedge clk) begin
        if (!resetn) begin
            active    = 1'b0;
            done_q    = 1'b0;
            enabled_q = 1'b0;
        end else begin
            check_count++;
            if (int'(outstanding) > dma_pkg::MAX_OUTSTANDING) begin
                error_count++;
                $display("[FAIL] outstanding expected <= 0x%0h got 0x%0h at %0t",
                         dma_pkg::MAX_OUTSTANDING, outstanding, $time);
            end
            if (busy) begin
                check_value("xfer_ready", 1'b0, xfer_ready);
            end
            if (!enabled) begin
                check_value("m_valid", 1'b0, m_valid);
            end
            if (enabled_q && !enabled) begin
                check_value("outstanding", '0, outstanding);
            end
            if (!active) begin
                check_value("busy", 1'b0, busy);
            end

            // A source beat moves only together with a sink beat
            if (s_valid) begin
                check_value("s_ready", m_valid && m_ready, s_ready);
            end

            if (xfer_valid && xfer_ready) begin
                if (active) begin
                    report_error("transfer accepted while another one is open");
                end
                active          = 1'b1;
                beats_expected  = int'(xfer_beats) + 1;
                beat_index      = 0;
                errors_at_start = error_count;
            end

            if (m_valid && m_ready) begin
                if (!active) begin
                    report_error("sink beat outside of a transfer");
                end else begin
                    beat_index++;
                    check_value("m_data", next_data, m_data);
                    check_value("m_last", expected_last(beat_index, beats_expected), m_last);
                    if (beat_index > beats_expected) begin
                        report_error("more sink beats than the transfer length");
                    end
                end
                // Source counts up across all transfers
                next_data = next_data + 1;
            end

            if (active && beat_index > 0 && !xfer_done) begin
                check_value("busy", 1'b1, busy);
            end

            if (xfer_done) begin
                check_value("busy", 1'b0, busy);
                if (done_q) begin
                    report_error("xfer_done stayed high for more than one cycle");
                end
                if (!active) begin
                    report_error("xfer_done without an open transfer");
                end else begin
                    check_value("beat_count", beats_expected, beat_index);
                    xfer_count++;
                    $display("transfer %0d finished: %0d beats, %0d errors",
                             xfer_count, beat_index, error_count - errors_at_start);
                    active = 1'b0;
                end
            end

            done_q    = xfer_done;
            enabled_q = enabled;
        end
    end

endmodule

// ==== verif/tb_dma_burst_mover.sv ====
`timescale 1ns/1ps

module tb_dma_burst_mover;

    localparam int NUM_ROWS = 8;

    // Columns: length minus one, source gap percent, sink stall percent, sync_id pulse
    localparam int STIM [NUM_ROWS][4] = '{
        '{  0,  0,  0, 0},
        '{ 15, 20, 10, 0},
        '{ 16, 10, 30, 0},
        '{ 17, 30, 20, 1},
        '{100, 25, 25, 0},
        '{255, 10, 10, 0},
        '{ 31, 50, 50, 1},
        '{ 47,  0, 60, 0}
    };

    localparam int STALL_MARGIN    = 10;
    localparam int OVERHEAD_CYCLES = 400;

    logic                                 clk;
    logic                                 resetn;
    logic                                 enable;
    logic                                 enabled;
    logic                                 sync_id;
    logic                                 xfer_valid;
    logic [dma_pkg::XFER_LEN_WIDTH-1:0]   xfer_beats;
    logic                                 xfer_ready;
    logic                                 s_valid;
    logic                                 s_ready;
    logic [dma_pkg::DATA_WIDTH-1:0]       s_data;
    logic                                 m_valid;
    logic                                 m_ready;
    logic [dma_pkg::DATA_WIDTH-1:0]       m_data;
    logic                                 m_last;
    logic                                 busy;
    logic                                 xfer_done;
    logic [dma_pkg::ID_WIDTH-1:0]         outstanding;

    int seed;
    int gap_pct;
    int stall_pct;
    bit hold_valid;
    bit src_fire;
    int cycle_count;
    int cycle_limit;

    dma_burst_mover i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .enabled     (enabled),
        .sync_id     (sync_id),
        .xfer_valid  (xfer_valid),
        .xfer_beats  (xfer_beats),
        .xfer_ready  (xfer_ready),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_data      (s_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .m_last      (m_last),
        .busy        (busy),
        .xfer_done   (xfer_done),
        .outstanding (outstanding)
    );

    dma_checker i_checker (
        .clk         (clk),
        .resetn      (resetn),
        .enabled     (enabled),
        .xfer_valid  (xfer_valid),
        .xfer_beats  (xfer_beats),
        .xfer_ready  (xfer_ready),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .m_last      (m_last),
        .busy        (busy),
        .xfer_done   (xfer_done),
        .outstanding (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic bit chance(input int pct);
        int unsigned r;
        r = $unsigned($random(seed));
        return (r % 100) < pct;
    endfunction

    function automatic int timeout_limit();
        int beats;
        beats = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            beats += STIM[i][0] + 1;
        end
        return beats * STALL_MARGIN + OVERHEAD_CYCLES;
    endfunction

    always @(negedge clk) begin
        src_fire = s_valid && s_ready;
    end

    // Source holds a beat until taken, sink stalls at random
    always @(posedge clk) begin
        #1;
        if (resetn) begin
            if (src_fire) begin
                s_data = s_data + 1;
            end
            if (!s_valid || src_fire) begin
                s_valid = hold_valid || !chance(gap_pct);
            end
            m_ready = !chance(stall_pct);
        end
    end

    task automatic run_transfer(input int row);
        gap_pct   = STIM[row][1];
        stall_pct = STIM[row][2];
        if (STIM[row][3] != 0) begin
            // IDs are equal while idle
            sync_id = 1'b1;
            @(posedge clk);
            #1;
            sync_id = 1'b0;
        end
        xfer_beats = STIM[row][0][dma_pkg::XFER_LEN_WIDTH-1:0];
        xfer_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!xfer_ready);
        @(posedge clk);
        #1;
        xfer_valid = 1'b0;
        do begin
            @(negedge clk);
        end while (!xfer_done);
        @(posedge clk);
        #1;
    endtask

    initial begin
        cycle_count = 0;
        cycle_limit = timeout_limit();
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        resetn     = 1'b0;
        enable     = 1'b0;
        sync_id    = 1'b0;
        xfer_valid = 1'b0;
        xfer_beats = '0;
        s_valid    = 1'b0;
        s_data     = '0;
        m_ready    = 1'b0;
        seed       = 48039;
        gap_pct    = 0;
        stall_pct  = 0;
        hold_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        enable = 1'b1;

        for (int row = 0; row < NUM_ROWS; row++) begin
            run_transfer(row);
        end

        // Nothing pending, so a held s_valid must never reach the sink
        hold_valid = 1'b1;
        stall_pct  = 0;
        enable     = 1'b0;
        do begin
            @(negedge clk);
        end while (enabled);
        repeat (20) @(negedge clk);

        $display("Transfers %0d of %0d, checks %0d, errors %0d", i_checker.xfer_count,
                 NUM_ROWS, i_checker.check_count, i_checker.error_count);
        if (i_checker.error_count == 0 && i_checker.xfer_count == NUM_ROWS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== dma_burst_mover.f ====
hdl/dma_pkg.sv
hdl/burst_splitter.sv
hdl/data_transfer.sv
hdl/transfer_tracker.sv
hdl/dma_burst_mover.sv
verif/dma_checker.sv
verif/tb_dma_burst_mover.sv

// ==== Makefile ====
SIM          ?= verilator
TOP          ?= tb_dma_burst_mover
RTL_TOP      ?= dma_burst_mover
FILELIST     ?= dma_burst_mover.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log

COMMON_FLAGS ?= --timing -Wno-fatal
LINT_FLAGS   ?= --lint-only
SIM_FLAGS    ?= --binary -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(SIM) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || \
		(echo "No pass message found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
